// ==== logic/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ************************************************************
// address split, 32-bit byte address
// ************************************************************

// byte offset inside a line
`define CACHE_OFFSET_BITS 5
// set index
`define CACHE_INDEX_BITS 4
// whatever is left above index and offset
`define CACHE_TAG_BITS 23

// ************************************************************
// geometry
// ************************************************************

// four-way set associative
`define CACHE_WAYS 4
// one set per index value
`define CACHE_SETS (1 << `CACHE_INDEX_BITS)
// 32-byte lines
`define CACHE_LINE_BITS 256
// one enable per line byte
`define CACHE_MASK_BITS 32

`endif

// ==== logic/cache_pkg.sv ====
package cache_pkg;

`include "cache_cfg.svh"

    // full byte address, tag + index + offset
    typedef logic [`CACHE_TAG_BITS+`CACHE_INDEX_BITS+`CACHE_OFFSET_BITS-1:0] addr_t;

    // address fields
    typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] set_t;

    // way number, four ways
    typedef logic [1:0] way_t;

    // one whole line and its byte enables
    typedef logic [`CACHE_LINE_BITS-1:0] line_t;
    typedef logic [`CACHE_MASK_BITS-1:0] mask_t;

    // controller states
    //   IDLE      wait for a cpu request
    //   LOOKUP    tag compare, respond on hit
    //   WRITEBACK dirty victim out to memory
    //   FILL      new line in from memory
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL
    } ctrl_state_t;

endpackage : cache_pkg

// ==== logic/way_store.sv ====
`timescale 1ns/10ps
`include "cache_cfg.svh"

module way_store #(
    // tag for the tag ways, whole line for the data ways
    parameter type payload_t = logic
) (
    input  logic            clk,
    input  logic            we,
    input  cache_pkg::set_t set,
    input  payload_t        din,
    output payload_t        dout
);

    // ************************************************************
    // one entry per set
    // ************************************************************

    // contents are meaningless until the valid bit is set
    payload_t mem [`CACHE_SETS];

    // write on the edge, same set as the read
    always_ff @(posedge clk) begin
        if (we) begin
            mem[set] <= din;
        end
    end

    // read is combinational
    // so lookup and response fit in one cycle
    assign dout = mem[set];

endmodule : way_store

// ==== logic/tag_match.sv ====
`timescale 1ns/10ps
`include "cache_cfg.svh"

module tag_match (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::set_t         set,
    input  cache_pkg::tag_t         tag,
    // active way, hit way or victim
    input  cache_pkg::way_t         way,
    input  logic                    tag_we,
    input  logic                    dirty_set,
    input  logic                    dirty_clear,
    output logic                    hit,
    output cache_pkg::way_t         hit_way,
    output logic [`CACHE_WAYS-1:0]  valid_ways,
    output logic                    victim_valid,
    output logic                    victim_dirty,
    output cache_pkg::tag_t         victim_tag
);

    cache_pkg::tag_t tag_out [`CACHE_WAYS];

    // status bits, per set one bit per way
    logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] dirty_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] match;

    // ************************************************************
    // tag ways
    // ************************************************************

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        way_store #(
            .payload_t (cache_pkg::tag_t)
        ) i_tag_store (
            .clk  (clk),
            .we   (tag_we && (way == cache_pkg::way_t'(w))),
            .set  (set),
            .din  (tag),
            .dout (tag_out[w])
        );

        assign match[w] = valid_ways[w] && (tag_out[w] == tag);
    end

    // ************************************************************
    // valid and dirty bits
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            // refill, new line is clean
            if (tag_we) begin
                valid_q[set][way] <= 1'b1;
                dirty_q[set][way] <= 1'b0;
            end
            if (dirty_set) begin
                dirty_q[set][way] <= 1'b1;
            end
            // written back
            if (dirty_clear) begin
                dirty_q[set][way] <= 1'b0;
            end
        end
    end

    assign valid_ways = valid_q[set];

    // parallel compare, at most one way matches
    assign hit = |match;

    always_comb begin
        hit_way = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    // state of the active way
    assign victim_valid = valid_q[set][way];
    assign victim_dirty = dirty_q[set][way];
    assign victim_tag   = tag_out[way];

endmodule : tag_match

// ==== logic/data_ways.sv ====
`timescale 1ns/10ps
`include "cache_cfg.svh"

module data_ways (
    input  logic             clk,
    input  cache_pkg::set_t  set,
    // active way for read and write
    input  cache_pkg::way_t  way,
    input  logic             data_we,
    // refill writes the memory line whole
    input  logic             fill_sel,
    input  cache_pkg::line_t mem_wdata,
    input  cache_pkg::mask_t mem_byte_enable,
    input  cache_pkg::line_t pmem_rdata,
    output cache_pkg::line_t line_out
);

    cache_pkg::line_t data_out [`CACHE_WAYS];
    cache_pkg::line_t merged;
    cache_pkg::line_t line_in;

    // ************************************************************
    // byte merge
    // ************************************************************

    // enabled bytes from the cpu, the rest from the stored line
    always_comb begin
        merged = line_out;
        for (int b = 0; b < `CACHE_MASK_BITS; b++) begin
            if (mem_byte_enable[b]) begin
                merged[8*b +: 8] = mem_wdata[8*b +: 8];
            end
        end
    end

    assign line_in = fill_sel ? pmem_rdata : merged;

    // ************************************************************
    // data ways
    // ************************************************************

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        way_store #(
            .payload_t (cache_pkg::line_t)
        ) i_data_store (
            .clk  (clk),
            // only the active way takes the write
            .we   (data_we && (way == cache_pkg::way_t'(w))),
            .set  (set),
            .din  (line_in),
            .dout (data_out[w])
        );
    end

    // read data on a hit, write-back data on an eviction
    assign line_out = data_out[way];

endmodule : data_ways

// ==== logic/victim_counter.sv ====
`timescale 1ns/10ps
`include "cache_cfg.svh"

module victim_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::set_t         set,
    // valid bits of the addressed set
    input  logic [`CACHE_WAYS-1:0]  valid_ways,
    // one pulse per completed refill
    input  logic                    fill_done,
    output cache_pkg::way_t         victim_way
);

    // round-robin pointer, one per set
    cache_pkg::way_t ptr [`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                ptr[s] <= '0;
            end
        end else if (fill_done) begin
            // two-bit pointer wraps by itself
            ptr[set] <= ptr[set] + cache_pkg::way_t'(1);
        end
    end

    // invalid way first, lowest number wins
    // otherwise the pointer of this set
    always_comb begin
        victim_way = ptr[set];
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_ways[w]) begin
                victim_way = cache_pkg::way_t'(w);
            end
        end
    end

endmodule : victim_counter

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/10ps

module cache_ctrl (
    input  logic clk,
    input  logic rst,

    // cpu request
    input  logic mem_read,
    input  logic mem_write,

    // lookup result for the active way
    input  logic hit,
    input  logic victim_valid,
    input  logic victim_dirty,

    // memory handshake
    input  logic pmem_resp,

    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,

    // array strobes
    output logic tag_we,
    output logic data_we,
    output logic fill_sel,
    output logic dirty_set,
    output logic dirty_clear,
    output logic fill_done
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t next_state;

    logic req;

    assign req = mem_read | mem_write;

    // ************************************************************
    // state register
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ************************************************************
    // next state and strobes
    // ************************************************************

    always_comb begin
        next_state  = state;
        mem_resp    = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;
        tag_we      = 1'b0;
        data_we     = 1'b0;
        fill_sel    = 1'b0;
        dirty_set   = 1'b0;
        dirty_clear = 1'b0;
        fill_done   = 1'b0;

        case (state)
            cache_pkg::IDLE: begin
                // request sampled here, answered in lookup
                if (req) begin
                    next_state = cache_pkg::LOOKUP;
                end
            end

            cache_pkg::LOOKUP: begin
                if (!req) begin
                    // request vanished, nothing to answer
                    next_state = cache_pkg::IDLE;
                end else if (hit) begin
                    mem_resp   = 1'b1;
                    next_state = cache_pkg::IDLE;
                    // write hit merges bytes and marks the line dirty
                    if (mem_write) begin
                        data_we   = 1'b1;
                        dirty_set = 1'b1;
                    end
                end else if (victim_valid && victim_dirty) begin
                    next_state = cache_pkg::WRITEBACK;
                end else begin
                    next_state = cache_pkg::FILL;
                end
            end

            cache_pkg::WRITEBACK: begin
                // victim line out, held until memory answers
                pmem_write = 1'b1;
                if (pmem_resp) begin
                    dirty_clear = 1'b1;
                    next_state  = cache_pkg::FILL;
                end
            end

            cache_pkg::FILL: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    // line, tag and valid on this edge
                    tag_we     = 1'b1;
                    data_we    = 1'b1;
                    fill_sel   = 1'b1;
                    fill_done  = 1'b1;
                    // lookup again, which now hits
                    next_state = cache_pkg::LOOKUP;
                end
            end

            default: begin
                next_state = cache_pkg::IDLE;
            end
        endcase
    end

endmodule : cache_ctrl

// ==== logic/setassoc_cache.sv ====
`timescale 1ns/10ps
`include "cache_cfg.svh"

module setassoc_cache (
    input  logic             clk,
    input  logic             rst,

    // cpu side
    input  cache_pkg::addr_t mem_address,
    input  logic             mem_read,
    input  logic             mem_write,
    input  cache_pkg::mask_t mem_byte_enable,
    input  cache_pkg::line_t mem_wdata,
    output cache_pkg::line_t mem_rdata,
    output logic             mem_resp,

    // memory side
    output cache_pkg::addr_t pmem_address,
    output logic             pmem_read,
    output logic             pmem_write,
    output cache_pkg::line_t pmem_wdata,
    input  cache_pkg::line_t pmem_rdata,
    input  logic             pmem_resp
);

    cache_pkg::tag_t         tag;
    cache_pkg::set_t         set;
    cache_pkg::way_t         way;
    cache_pkg::way_t         hit_way;
    cache_pkg::way_t         victim_way;
    cache_pkg::tag_t         victim_tag;
    cache_pkg::line_t        line_out;
    logic [`CACHE_WAYS-1:0]  valid_ways;
    logic                    hit;
    logic                    victim_valid;
    logic                    victim_dirty;
    logic                    tag_we;
    logic                    data_we;
    logic                    fill_sel;
    logic                    dirty_set;
    logic                    dirty_clear;
    logic                    fill_done;

    // ************************************************************
    // address split and way select
    // ************************************************************

    assign tag = mem_address[$bits(cache_pkg::addr_t)-1 -: `CACHE_TAG_BITS];
    assign set = mem_address[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];

    // miss path works on the victim
    assign way = hit ? hit_way : victim_way;

    // victim address while writing back, request line otherwise
    assign pmem_address = pmem_write ?
        {victim_tag, set, {`CACHE_OFFSET_BITS{1'b0}}} :
        {tag, set, {`CACHE_OFFSET_BITS{1'b0}}};

    assign mem_rdata  = line_out;
    assign pmem_wdata = line_out;

    // ************************************************************
    // blocks
    // ************************************************************

    cache_ctrl i_cache_ctrl (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .hit          (hit),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .pmem_resp    (pmem_resp),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .tag_we       (tag_we),
        .data_we      (data_we),
        .fill_sel     (fill_sel),
        .dirty_set    (dirty_set),
        .dirty_clear  (dirty_clear),
        .fill_done    (fill_done)
    );

    victim_counter i_victim_counter (
        .clk        (clk),
        .rst        (rst),
        .set        (set),
        .valid_ways (valid_ways),
        .fill_done  (fill_done),
        .victim_way (victim_way)
    );

    tag_match i_tag_match (
        .clk          (clk),
        .rst          (rst),
        .set          (set),
        .tag          (tag),
        .way          (way),
        .tag_we       (tag_we),
        .dirty_set    (dirty_set),
        .dirty_clear  (dirty_clear),
        .hit          (hit),
        .hit_way      (hit_way),
        .valid_ways   (valid_ways),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    data_ways i_data_ways (
        .clk             (clk),
        .set             (set),
        .way             (way),
        .data_we         (data_we),
        .fill_sel        (fill_sel),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .pmem_rdata      (pmem_rdata),
        .line_out        (line_out)
    );

endmodule : setassoc_cache

// ==== sim/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    // 40 ns period
    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

endmodule : tb_clock

// ==== sim/cache_asserts.sv ====
`timescale 1ns/10ps

module cache_asserts (
    input logic             clk,
    input logic             rst,
    input logic             mem_read,
    input logic             mem_write,
    input logic             mem_resp,
    input logic             pmem_read,
    input logic             pmem_write,
    input logic             pmem_resp,
    input cache_pkg::addr_t pmem_address
);

    // ************************************************************
    // memory side
    // ************************************************************

    // one kind of memory request at a time
    a_single_req: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high in the same cycle");

    // request address held until the memory answers
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        ((pmem_read || pmem_write) && !pmem_resp) |=> $stable(pmem_address))
        else $error("pmem_address moved while a request was pending");

    // ************************************************************
    // cpu side
    // ************************************************************

    // response is a one-cycle pulse
    a_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        mem_resp |=> !mem_resp)
        else $error("mem_resp high for more than one cycle");

    // and only answers a live request
    a_resp_in_req: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (mem_read ^ mem_write))
        else $error("mem_resp outside a single read or write request");

endmodule : cache_asserts

// attach to the cache top level
bind setassoc_cache cache_asserts i_cache_asserts (
    .clk          (clk),
    .rst          (rst),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_resp     (mem_resp),
    .pmem_read    (pmem_read),
    .pmem_write   (pmem_write),
    .pmem_resp    (pmem_resp),
    .pmem_address (pmem_address)
);

// ==== sim/cache_tb.sv ====
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_tb;

    localparam int n_rand = 300;
    localparam int n_direct = 7;
    // a miss with write-back stays well under 20 cycles
    localparam int watchdog_cycles = (n_rand + n_direct) * 20 + 200;

    logic             clk;
    logic             rst;
    cache_pkg::addr_t mem_address;
    logic             mem_read;
    logic             mem_write;
    cache_pkg::mask_t mem_byte_enable;
    cache_pkg::line_t mem_wdata;
    cache_pkg::line_t mem_rdata;
    logic             mem_resp;
    cache_pkg::addr_t pmem_address;
    logic             pmem_read;
    logic             pmem_write;
    cache_pkg::line_t pmem_wdata;
    cache_pkg::line_t pmem_rdata;
    logic             pmem_resp;

    integer seed;
    int     wb_count;
    logic   last_hit;

    // backing memory and cpu view kept sparse by line address
    cache_pkg::line_t mem_lines [cache_pkg::addr_t];
    cache_pkg::line_t cpu_lines [cache_pkg::addr_t];

    // reference cache with round robin and invalid ways first
    logic            ref_valid [`CACHE_SETS][`CACHE_WAYS];
    logic            ref_dirty [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::tag_t ref_tag   [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::way_t ref_ptr   [`CACHE_SETS];

    tb_clock i_tb_clock (
        .clk (clk)
    );

    setassoc_cache i_setassoc_cache (
        .clk             (clk),
        .rst             (rst),
        .mem_address     (mem_address),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .pmem_address    (pmem_address),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_resp       (pmem_resp)
    );

    // ************************************************************
    // helpers and compare tasks
    // ************************************************************

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_line(input string name, input cache_pkg::line_t got,
                              input cache_pkg::line_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t got,
                              input cache_pkg::addr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // contents of untouched memory
    // odd multiply spreads every address bit
    function automatic cache_pkg::line_t fill_pattern(input cache_pkg::addr_t a);
        cache_pkg::line_t l;
        for (int i = 0; i < `CACHE_LINE_BITS / 32; i++) begin
            l[32*i +: 32] = (a | 32'(i)) * 32'h9e3779b1;
        end
        return l;
    endfunction

    function automatic cache_pkg::line_t random_line();
        cache_pkg::line_t l;
        for (int i = 0; i < `CACHE_LINE_BITS / 32; i++) begin
            l[32*i +: 32] = $random(seed);
        end
        return l;
    endfunction

    // enabled bytes replaced and others kept
    function automatic cache_pkg::line_t merge_bytes(input cache_pkg::line_t old,
            input cache_pkg::line_t wdata, input cache_pkg::mask_t mask);
        cache_pkg::line_t l;
        l = old;
        for (int b = 0; b < `CACHE_MASK_BITS; b++) begin
            if (mask[b]) begin
                l[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return l;
    endfunction

    // set 12 is left alone by the random phase
    function automatic cache_pkg::addr_t replace_addr(input int k);
        return {cache_pkg::tag_t'(32'h7000 + k), 4'd12, 5'd8};
    endfunction

    // ************************************************************
    // one cpu access with memory model and checks
    // ************************************************************

    task automatic access(input cache_pkg::addr_t addr, input logic is_write,
                          input cache_pkg::line_t wdata, input cache_pkg::mask_t mask);
        cache_pkg::addr_t line_a;
        cache_pkg::addr_t victim_a;
        cache_pkg::set_t  s;
        cache_pkg::tag_t  t;
        cache_pkg::way_t  w;
        logic [31:0]      r;
        logic             exp_hit;
        logic             exp_wb;
        logic             done;
        logic             resp_next;
        int               cycles;
        int               wait_left;
        int               n_wr;
        int               n_rd;

        line_a = {addr[31:`CACHE_OFFSET_BITS], {`CACHE_OFFSET_BITS{1'b0}}};
        s = addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
        t = addr[31 -: `CACHE_TAG_BITS];
        if (!cpu_lines.exists(line_a)) begin
            cpu_lines[line_a] = fill_pattern(line_a);
            mem_lines[line_a] = fill_pattern(line_a);
        end

        // predicted way is the hit way or the lowest invalid way or the pointer
        exp_hit = 1'b0;
        w = ref_ptr[s];
        for (int i = `CACHE_WAYS - 1; i >= 0; i--) begin
            if (!ref_valid[s][i]) begin
                w = cache_pkg::way_t'(i);
            end
        end
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            if (ref_valid[s][i] && ref_tag[s][i] == t) begin
                exp_hit = 1'b1;
                w = cache_pkg::way_t'(i);
            end
        end
        exp_wb = !exp_hit && ref_valid[s][w] && ref_dirty[s][w];
        victim_a = {ref_tag[s][w], s, {`CACHE_OFFSET_BITS{1'b0}}};

        @(posedge clk);
        mem_address     <= addr;
        mem_read        <= !is_write;
        mem_write       <= is_write;
        mem_byte_enable <= mask;
        mem_wdata       <= wdata;
        done = 1'b0;
        cycles = 0;
        wait_left = 0;
        n_wr = 0;
        n_rd = 0;

        while (!done) begin
            @(negedge clk);
            cycles++;
            resp_next = 1'b0;
            if (mem_resp) begin
                done = 1'b1;
                if (!is_write) begin
                    check_line("mem_rdata", mem_rdata, cpu_lines[line_a]);
                end
            end else if ((pmem_read || pmem_write) && !pmem_resp) begin
                if (wait_left == 0) begin
                    // new memory request
                    if (exp_hit || n_rd != 0) begin
                        stop_run("memory request where the model expects none");
                    end
                    check_bit("pmem_write", pmem_write, exp_wb && n_wr == 0);
                    check_bit("pmem_read", pmem_read, !(exp_wb && n_wr == 0));
                    if (pmem_write) begin
                        check_addr("pmem_address", pmem_address, victim_a);
                        check_line("pmem_wdata", pmem_wdata, cpu_lines[victim_a]);
                        mem_lines[victim_a] = pmem_wdata;
                        n_wr++;
                    end else begin
                        check_addr("pmem_address", pmem_address, line_a);
                        n_rd++;
                    end
                    // answer after 1 to 4 cycles
                    r = $random(seed);
                    wait_left = 1 + int'(r[1:0]);
                end
                wait_left--;
                resp_next = (wait_left == 0);
            end
            @(posedge clk);
            pmem_resp <= resp_next;
            if (resp_next) begin
                pmem_rdata <= mem_lines[line_a];
            end
            if (done) begin
                mem_read  <= 1'b0;
                mem_write <= 1'b0;
            end
        end

        if (exp_hit && cycles != 2) begin
            stop_run("hit answered later than one cycle after the request");
        end
        if (!exp_hit && (n_rd != 1 || n_wr != (exp_wb ? 1 : 0))) begin
            stop_run("miss finished without the expected memory traffic");
        end

        // model update
        if (!exp_hit) begin
            ref_valid[s][w] = 1'b1;
            ref_dirty[s][w] = 1'b0;
            ref_tag[s][w]   = t;
            ref_ptr[s]      = ref_ptr[s] + 2'd1;
        end
        if (is_write) begin
            ref_dirty[s][w]   = 1'b1;
            cpu_lines[line_a] = merge_bytes(cpu_lines[line_a], wdata, mask);
        end
        wb_count += n_wr;
        // a hit as seen on the bus shows no memory traffic
        last_hit = (n_rd == 0) && (n_wr == 0);
    endtask

    // ************************************************************
    // watchdog
    // ************************************************************

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        stop_run("timeout, the test did not finish in the expected time");
    end

    // ************************************************************
    // main sequence
    // ************************************************************

    initial begin
        logic [31:0]          r;
        cache_pkg::tag_t      t;
        cache_pkg::set_t      s;
        logic [4:0]           o;
        cache_pkg::line_t     wd;
        cache_pkg::mask_t     m;

        seed = 31;
        wb_count = 0;
        last_hit = 1'b0;
        rst             <= 1'b1;
        mem_address     <= '0;
        mem_read        <= 1'b0;
        mem_write       <= 1'b0;
        mem_byte_enable <= '0;
        mem_wdata       <= '0;
        pmem_rdata      <= '0;
        pmem_resp       <= 1'b0;
        for (int i = 0; i < `CACHE_SETS; i++) begin
            ref_ptr[i] = '0;
            for (int j = 0; j < `CACHE_WAYS; j++) begin
                ref_valid[i][j] = 1'b0;
                ref_dirty[i][j] = 1'b0;
                ref_tag[i][j]   = '0;
            end
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // quiet after reset
        @(negedge clk);
        check_bit("mem_resp", mem_resp, 1'b0);
        check_bit("pmem_read", pmem_read, 1'b0);
        check_bit("pmem_write", pmem_write, 1'b0);

        // six tags over sets 0 to 7 force evictions
        for (int k = 0; k < n_rand; k++) begin
            r = $random(seed);
            t = cache_pkg::tag_t'(r[15:8] % 8'd6) + 23'h40;
            s = {1'b0, r[2:0]};
            o = r[20:16];
            wd = random_line();
            m = $random(seed);
            // some full-line writes
            if (r[26]) begin
                m = '1;
            end
            access({t, s, o}, r[24], wd, m);
        end
        if (wb_count == 0) begin
            stop_run("random phase never evicted a dirty line");
        end

        // tags A to E into one empty set
        for (int k = 0; k < 5; k++) begin
            access(replace_addr(k), 1'b0, '0, '0);
            check_bit("hit", last_hit, 1'b0);
        end
        // B is still cached after E
        access(replace_addr(1), 1'b0, '0, '0);
        check_bit("hit", last_hit, 1'b1);
        // A made room for E
        access(replace_addr(0), 1'b0, '0, '0);
        check_bit("hit", last_hit, 1'b0);

        $display("Verification passed");
        $finish;
    end

endmodule : cache_tb

// ==== setassoc_cache.f ====
+incdir+logic
logic/cache_pkg.sv
logic/way_store.sv
logic/tag_match.sv
logic/data_ways.sv
logic/victim_counter.sv
logic/cache_ctrl.sv
logic/setassoc_cache.sv
sim/tb_clock.sv
sim/cache_asserts.sv
sim/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it
# the exit status follows the pass message in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module cache_tb \
    -f setassoc_cache.f \
    && ./obj_dir/Vcache_tb | tee /dev/stderr | grep "^Verification passed$" > /dev/null \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }
